// File: hw/lsu_params.svh
////////////////////
// load/store unit parameters
// bus width, byte lanes, credit depth and access size codes
////////////////////

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define LSU_XLEN      32            // data and address width
`define LSU_NBYTES    4             // byte lanes, also the step to the second beat
`define LSU_CREDITS   2             // bus beats allowed in flight

// access size codes
`define LSU_TYPE_WORD 2'b00
`define LSU_TYPE_HALF 2'b01
`define LSU_TYPE_BYTE 2'b10

`define LSU_ERR_BASE  32'h0000_00c0 // word pattern answered with a bus error
`define LSU_ERR_MASK  32'h0000_00f8 // covers two adjacent words

`endif

// File: hw/lsu_pkg.sv
////////////////////
// load/store unit types
// access size, execute-side request, result and beat descriptor
////////////////////

`include "lsu_params.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    LSU_WORD = `LSU_TYPE_WORD,
    LSU_HALF = `LSU_TYPE_HALF,
    LSU_BYTE = `LSU_TYPE_BYTE
  } lsu_type_e;

  // operation from the execute stage
  typedef struct packed {
    logic                 we;
    lsu_type_e            dtype;
    logic                 sign_ext;
    logic [`LSU_XLEN-1:0] addr;      // byte address, any alignment
    logic [`LSU_XLEN-1:0] wdata;
  } lsu_req_t;

  // one completed access
  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;     // extended load data, zero on stores
    logic                 err;
    logic                 we;
    logic [`LSU_XLEN-1:0] addr;      // faulting address
  } lsu_rsp_t;

  // granted beat, handed from the request side to the response side
  typedef struct packed {
    logic [1:0]           offset;
    lsu_type_e            dtype;
    logic                 sign_ext;
    logic                 we;
    logic                 first;     // first half of a split access
    logic [`LSU_XLEN-1:0] addr;
  } lsu_beat_t;

endpackage

// File: hw/lsu_req_stage.sv
////////////////////
// lsu request stage
// takes one operation, splits misaligned ones into two word beats,
// drives the bus request side and tracks bus credits
////////////////////

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_req_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  output logic                  req_ready_o,
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output logic [`LSU_XLEN-1:0]  data_addr_o,
  output logic                  data_we_o,
  output logic [`LSU_NBYTES-1:0] data_be_o,
  output logic [`LSU_XLEN-1:0]  data_wdata_o,
  output logic                  beat_valid_o,
  output lsu_pkg::lsu_beat_t    beat_o,
  input  logic                  credit_return_i
);

  localparam int CntW = $clog2(`LSU_CREDITS + 1);
  localparam logic [CntW-1:0] CntFull = `LSU_CREDITS;
  localparam logic [`LSU_XLEN-1:0] Step = `LSU_NBYTES;

  typedef enum logic [1:0] {ST_IDLE, ST_FIRST, ST_SECOND} state_e;

  state_e            state_q, state_d;
  lsu_pkg::lsu_req_t op_q;                     // accepted operation
  logic [CntW-1:0]   credit_q, credit_d;
  logic              accept, grant;
  logic              split, second;
  logic [1:0]        offset;
  logic [`LSU_XLEN-1:0] addr_next, beat_addr;

  assign accept = req_valid_i & req_ready_o;
  assign grant  = data_req_o & data_gnt_i;
  assign offset = op_q.addr[1:0];
  assign second = (state_q == ST_SECOND);

  // word off a boundary, or a half that crosses into the next word
  assign split = ((op_q.dtype == lsu_pkg::LSU_WORD) && (offset != 2'b00)) ||
                 ((op_q.dtype == lsu_pkg::LSU_HALF) && (offset == 2'b11));

  assign addr_next = {op_q.addr[`LSU_XLEN-1:2], 2'b00} + Step;
  assign beat_addr = second ? addr_next : op_q.addr;

  ////////////////////
  // control
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (accept) state_d = ST_FIRST;
      ST_FIRST:  if (grant) state_d = split ? ST_SECOND : ST_IDLE;
      ST_SECOND: if (grant) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  // one spent per grant, one back per read-valid
  assign credit_d = credit_q - CntW'(grant) + CntW'(credit_return_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      credit_q <= CntFull;
    end else begin
      state_q  <= state_d;
      credit_q <= credit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) op_q <= req_i;
  end

  // full credits leave room for both halves of a split
  assign req_ready_o = (state_q == ST_IDLE) && (credit_q == CntFull);
  assign data_req_o  = (state_q inside {ST_FIRST, ST_SECOND}) && (credit_q != '0);

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    unique case (op_q.dtype)
      lsu_pkg::LSU_WORD: begin
        if (!second) begin
          data_be_o = 4'b1111 << offset;       // 1111, 1110, 1100, 1000
        end else begin
          data_be_o = ~(4'b1111 << offset);    // spill into next word
        end
      end
      lsu_pkg::LSU_HALF: begin
        if (!second) begin
          data_be_o = 4'b0011 << offset;       // top bit drops at offset 3
        end else begin
          data_be_o = 4'b0001;
        end
      end
      default: data_be_o = 4'b0001 << offset;  // byte
    endcase
  end

  // rotate store data so byte 0 lands on lane offset, the wrap serves beat two
  always_comb begin
    unique case (offset)
      2'b00:   data_wdata_o = op_q.wdata;
      2'b01:   data_wdata_o = {op_q.wdata[23:0], op_q.wdata[31:24]};
      2'b10:   data_wdata_o = {op_q.wdata[15:0], op_q.wdata[31:16]};
      default: data_wdata_o = {op_q.wdata[7:0], op_q.wdata[31:8]};
    endcase
  end

  assign data_addr_o = {beat_addr[`LSU_XLEN-1:2], 2'b00};
  assign data_we_o   = op_q.we;

  ////////////////////
  // beat descriptor
  ////////////////////

  assign beat_valid_o    = grant;
  assign beat_o.offset   = offset;
  assign beat_o.dtype    = op_q.dtype;
  assign beat_o.sign_ext = op_q.sign_ext;
  assign beat_o.we       = op_q.we;
  assign beat_o.first    = split & ~second;
  assign beat_o.addr     = beat_addr;            // op address or aligned second address

  // assertions
  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {ST_IDLE, ST_FIRST, ST_SECOND});

  // request must be held with a stable aligned address until granted
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
                                  $stable(data_be_o) && $stable(data_wdata_o));

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CntFull);

endmodule

// File: hw/lsu_rsp_stage.sv
////////////////////
// lsu response stage
// matches read-valid beats to queued descriptors, merges split loads,
// extends the result and hands credits back
////////////////////

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_rsp_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 beat_valid_i,
  input  lsu_pkg::lsu_beat_t   beat_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  input  logic [`LSU_XLEN-1:0] data_rdata_i,
  output logic                 credit_return_o,
  output logic                 rsp_valid_o,
  output lsu_pkg::lsu_rsp_t    rsp_o
);

  localparam int Depth = `LSU_CREDITS;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  lsu_pkg::lsu_beat_t   q_mem [Depth];         // in grant order
  lsu_pkg::lsu_beat_t   head;
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]      cnt_q;
  logic [`LSU_XLEN-1:8] rdata_q;               // upper bytes of the first beat
  logic [`LSU_XLEN-1:0] addr_q;                // operation address of a split
  logic                 err_q;                 // first beat erred
  logic                 split_fin;
  logic [`LSU_XLEN-1:0] rdata_w, rdata_h, rdata_b, rdata_ext;
  logic [15:0]          half;
  logic [7:0]           byte_sel;

  assign head = q_mem[rd_ptr_q];

  ////////////////////
  // descriptor queue
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) q_mem[wr_ptr_q] <= beat_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      err_q    <= 1'b0;
    end else begin
      if (beat_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (data_rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + CntW'(beat_valid_i) - CntW'(data_rvalid_i);
      if (data_rvalid_i && head.first) err_q <= data_err_i;
    end
  end

  // first half of a split: keep bytes and address, no result yet
  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && head.first) begin
      rdata_q <= data_rdata_i[`LSU_XLEN-1:8];
      addr_q  <= head.addr;
    end
  end

  ////////////////////
  // realign and extend
  ////////////////////

  always_comb begin
    unique case (head.offset)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (head.offset)
      2'b00:   half = data_rdata_i[15:0];
      2'b01:   half = data_rdata_i[23:8];
      2'b10:   half = data_rdata_i[31:16];
      default: half = {data_rdata_i[7:0], rdata_q[31:24]}; // crosses words
    endcase
  end

  assign byte_sel = data_rdata_i[{head.offset, 3'b000} +: 8];
  assign rdata_h  = {{16{head.sign_ext & half[15]}}, half};
  assign rdata_b  = {{24{head.sign_ext & byte_sel[7]}}, byte_sel};

  always_comb begin
    unique case (head.dtype)
      lsu_pkg::LSU_WORD: rdata_ext = rdata_w;
      lsu_pkg::LSU_HALF: rdata_ext = rdata_h;
      default:           rdata_ext = rdata_b;
    endcase
  end

  // head is the second beat of a split access
  assign split_fin = ((head.dtype == lsu_pkg::LSU_WORD) && (head.offset != 2'b00)) ||
                     ((head.dtype == lsu_pkg::LSU_HALF) && (head.offset == 2'b11));

  ////////////////////
  // outputs
  ////////////////////

  assign credit_return_o = data_rvalid_i;
  assign rsp_valid_o     = data_rvalid_i & ~head.first;
  assign rsp_o.rdata     = head.we ? '0 : rdata_ext;
  assign rsp_o.err       = data_err_i | (split_fin & err_q);
  assign rsp_o.we        = head.we;
  // second address only when the second beat alone erred
  assign rsp_o.addr      = (split_fin && !(data_err_i && !err_q)) ? addr_q : head.addr;

  a_err_with_rvalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_err_i |-> data_rvalid_i);

  a_rvalid_queued : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> (cnt_q != '0));

  // credits upstream keep grants within the queue depth
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_i |-> (cnt_q < CntW'(Depth)));

endmodule

// File: hw/lsu_core.sv
////////////////////
// load/store unit top
// request stage and response stage, joined by beats and credits
////////////////////

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // execute side
  input  logic                   req_valid_i,
  input  lsu_pkg::lsu_req_t      req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output lsu_pkg::lsu_rsp_t      rsp_o,
  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic [`LSU_XLEN-1:0]   data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_NBYTES-1:0] data_be_o,
  output logic [`LSU_XLEN-1:0]   data_wdata_o,
  input  logic [`LSU_XLEN-1:0]   data_rdata_i
);

  logic               beat_valid;              // one per grant
  lsu_pkg::lsu_beat_t beat;
  logic               credit_return;           // one per read-valid

  lsu_req_stage req_stage_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .beat_valid_o    (beat_valid),
    .beat_o          (beat),
    .credit_return_i (credit_return)
  );

  lsu_rsp_stage rsp_stage_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .beat_valid_i    (beat_valid),
    .beat_i          (beat),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_rdata_i    (data_rdata_i),
    .credit_return_o (credit_return),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o)
  );

endmodule

// File: tests/lsu_mem_model.sv
////////////////////
// data bus responder
// byte memory, random grant and read-valid delays, error window
////////////////////

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  output logic                   data_gnt_o,
  input  logic [`LSU_XLEN-1:0]   data_addr_i,
  input  logic                   data_we_i,
  input  logic [`LSU_NBYTES-1:0] data_be_i,
  input  logic [`LSU_XLEN-1:0]   data_wdata_i,
  output logic                   data_rvalid_o,
  output logic                   data_err_o,
  output logic [`LSU_XLEN-1:0]   data_rdata_o
);

  typedef struct packed {
    logic [31:0]          due;     // first cycle read-valid may show
    logic                 err;
    logic [`LSU_XLEN-1:0] rdata;
  } pend_t;

  logic [7:0]             mem [256];
  pend_t                  pend_q [$];   // granted beats, oldest first
  pend_t                  beat;
  logic [31:0]            cyc;
  int unsigned            wait_cnt;     // cycles left before grant
  logic                   rst_seen, req_seen, granted, delivered;
  logic [`LSU_XLEN-1:0]   addr_s, wdata_s;
  logic [`LSU_NBYTES-1:0] be_s;
  logic                   we_s;

  function automatic logic is_err_word(input logic [31:0] a);
    return (a & `LSU_ERR_MASK) == `LSU_ERR_BASE;
  endfunction

  // write enabled lanes unless erred, read back the whole word
  task automatic serve_beat();
    for (int k = 0; k < 4; k++) begin
      if (we_s && be_s[k] && !is_err_word(addr_s)) begin
        mem[{addr_s[7:2], 2'(k)}] = wdata_s[8*k +: 8];
      end
      beat.rdata[8*k +: 8] = mem[{addr_s[7:2], 2'(k)}];
    end
    beat.err = is_err_word(addr_s);
    beat.due = cyc + ($urandom % 3);    // 1 to 3 cycles after grant
    pend_q.push_back(beat);
  endtask

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = 8'(i * 37 + 90);  // odd step, all address bits count
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_err_o    = 1'b0;
    data_rdata_o  = '0;
    cyc           = '0;
    wait_cnt      = 0;
    forever begin
      @(negedge clk_i);                 // bus is stable mid cycle
      rst_seen  = rst_ni;
      req_seen  = data_req_i;
      granted   = data_req_i & data_gnt_o;
      delivered = data_rvalid_o;
      addr_s    = data_addr_i;
      we_s      = data_we_i;
      be_s      = data_be_i;
      wdata_s   = data_wdata_i;
      @(posedge clk_i);
      #2;
      cyc = cyc + 1;
      if (!rst_seen) begin
        pend_q.delete();
        wait_cnt = 0;
      end else begin
        if (delivered) pend_q.delete(0);
        if (granted) begin
          serve_beat();
          wait_cnt = $urandom % 4;      // 0 to 3 cycles to next grant
        end else if (req_seen && wait_cnt != 0) begin
          wait_cnt--;
        end
      end
      data_gnt_o = rst_seen && (wait_cnt == 0);
      if (pend_q.size() != 0 && pend_q[0].due <= cyc) begin
        data_rvalid_o = 1'b1;
        data_err_o    = pend_q[0].err;
        data_rdata_o  = pend_q[0].rdata;
      end else begin
        data_rvalid_o = 1'b0;
        data_err_o    = 1'b0;
        data_rdata_o  = '0;
      end
    end
  end

endmodule

// File: tests/tb_lsu_core.sv
////////////////////
// load/store unit testbench
// directed and random accesses checked against a shadow memory
////////////////////

`timescale 1ns/100ps
`include "lsu_params.svh"

module tb_lsu_core;

  localparam int NUM_RANDOM = 400;
  localparam int NUM_OPS    = 78 + NUM_RANDOM;  // directed plus random
  localparam int TIMEOUT    = 20 * NUM_OPS;     // cycles

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req_valid, req_ready, rsp_valid;
  lsu_pkg::lsu_req_t      req;
  lsu_pkg::lsu_rsp_t      rsp, exp_head;
  logic                   data_req, data_gnt, data_rvalid, data_err, data_we;
  logic [`LSU_XLEN-1:0]   data_addr, data_wdata, data_rdata;
  logic [`LSU_NBYTES-1:0] data_be;

  logic [7:0]        shadow [256];              // expected memory contents
  lsu_pkg::lsu_rsp_t exp_q [$];                 // expected results, issue order
  int                n_issued = 0;
  int                n_done   = 0;
  int                errors   = 0;
  int                cycles   = 0;
  logic [31:0]       rnd;

  always #10 clk = ~clk;

  lsu_core lsu_core_i (
    .clk_i (clk), .rst_ni (rst_n),
    .req_valid_i (req_valid), .req_i (req), .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid), .rsp_o (rsp),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  lsu_mem_model mem_i (
    .clk_i (clk), .rst_ni (rst_n),
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_addr_i (data_addr),
    .data_we_i (data_we), .data_be_i (data_be), .data_wdata_i (data_wdata),
    .data_rvalid_o (data_rvalid), .data_err_o (data_err), .data_rdata_o (data_rdata)
  );

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic is_err_word(input logic [31:0] a);
    return (a & `LSU_ERR_MASK) == `LSU_ERR_BASE;
  endfunction

  function automatic int size_bytes(input lsu_pkg::lsu_type_e dtype);
    case (dtype)
      lsu_pkg::LSU_WORD: return 4;
      lsu_pkg::LSU_HALF: return 2;
      default:           return 1;
    endcase
  endfunction

  function automatic lsu_pkg::lsu_rsp_t predict(input lsu_pkg::lsu_req_t op);
    lsu_pkg::lsu_rsp_t r;
    logic [31:0]       word0, word1, val, baddr;
    int                nbytes;
    logic              err0, err1;
    nbytes = size_bytes(op.dtype);
    word0  = {op.addr[31:2], 2'b00};
    word1  = word0 + `LSU_NBYTES;
    err0   = is_err_word(word0);
    err1   = ((int'(op.addr[1:0]) + nbytes) > 4) && is_err_word(word1);  // only if it crosses
    val    = '0;
    for (int i = 0; i < nbytes; i++) begin
      baddr = op.addr + 32'(i);
      val[8*i +: 8] = shadow[baddr[7:0]];       // little endian, wraps at 256
    end
    if (op.sign_ext && nbytes == 1 && val[7]) val[31:8] = '1;
    if (op.sign_ext && nbytes == 2 && val[15]) val[31:16] = '1;
    r.rdata = op.we ? '0 : val;
    r.err   = err0 | err1;
    r.we    = op.we;
    r.addr  = (err1 && !err0) ? word1 : op.addr;   // second word alone faulted
    return r;
  endfunction

  // erroring words keep their old bytes
  function automatic void store_shadow(input lsu_pkg::lsu_req_t op);
    logic [31:0] baddr;
    for (int i = 0; i < size_bytes(op.dtype); i++) begin
      baddr = op.addr + 32'(i);
      if (!is_err_word({baddr[31:2], 2'b00})) shadow[baddr[7:0]] = op.wdata[8*i +: 8];
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "result check failed");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // entered and left 2 ns after a rising edge
  task automatic issue(input logic we, input lsu_pkg::lsu_type_e dtype, input logic sext,
                       input logic [31:0] addr, input logic [31:0] wdata);
    req_valid    = 1'b1;
    req.we       = we;
    req.dtype    = dtype;
    req.sign_ext = sext;
    req.addr     = addr;
    req.wdata    = wdata;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    exp_q.push_back(predict(req));              // accepted at the coming edge
    if (we) store_shadow(req);
    n_issued++;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic load_op(input lsu_pkg::lsu_type_e dtype, input logic sext,
                         input logic [31:0] addr);
    issue(1'b0, dtype, sext, addr, '0);
  endtask

  task automatic store_op(input lsu_pkg::lsu_type_e dtype, input logic [31:0] addr);
    issue(1'b1, dtype, 1'b0, addr, $urandom);
  endtask

  initial begin
    logic [31:0] base;
    void'($urandom(32'hc02a_2018));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 37 + 90);  // same fill as the model
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // aligned loads at every legal offset, zero and sign extended
    for (int b = 0; b < 2; b++) begin
      for (int s = 0; s < 2; s++) begin
        base = 32'h10 + 32'(4 * b);
        load_op(lsu_pkg::LSU_WORD, s[0], base);
        for (int o = 0; o < 3; o++) load_op(lsu_pkg::LSU_HALF, s[0], base + 32'(o));
        for (int o = 0; o < 4; o++) load_op(lsu_pkg::LSU_BYTE, s[0], base + 32'(o));
      end
    end

    // stores of each size and offset, read back as words
    store_op(lsu_pkg::LSU_WORD, 32'h40);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h40);
    for (int o = 0; o < 3; o++) begin
      store_op(lsu_pkg::LSU_HALF, 32'h44 + 32'(o));
      load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h44);
    end
    for (int o = 0; o < 4; o++) begin
      store_op(lsu_pkg::LSU_BYTE, 32'h48 + 32'(o));
      load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h48);
    end

    // split accesses
    for (int o = 1; o < 4; o++) load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h60 + 32'(o));
    for (int s = 0; s < 2; s++) load_op(lsu_pkg::LSU_HALF, s[0], 32'h63);
    for (int o = 1; o < 4; o++) begin
      store_op(lsu_pkg::LSU_WORD, 32'h70 + 32'(o));
      load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h70);
      load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h74);
    end
    store_op(lsu_pkg::LSU_HALF, 32'h7b);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h78);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'h7c);

    // error window at 0xc0..0xc7, first beat, second beat and both
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc0);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hbd);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc5);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc2);
    load_op(lsu_pkg::LSU_HALF, 1'b1, 32'hbf);
    load_op(lsu_pkg::LSU_BYTE, 1'b1, 32'hc3);
    store_op(lsu_pkg::LSU_WORD, 32'hc4);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc4);
    store_op(lsu_pkg::LSU_WORD, 32'hbe);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hbc);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc0);
    store_op(lsu_pkg::LSU_BYTE, 32'hc1);
    load_op(lsu_pkg::LSU_WORD, 1'b0, 32'hc0);

    // random mix, with an idle cycle now and then
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $urandom;
      issue(rnd[31], lsu_pkg::lsu_type_e'(rnd[9:8] % 2'd3), rnd[10],
            {24'h0, rnd[7:0]}, $urandom);
      if (rnd[12]) begin
        @(posedge clk);
        #2;
      end
    end

    wait (n_done == n_issued);
    repeat (4) @(posedge clk);
    if (errors == 0 && exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "run ended with failed checks");
    end
  end

  ////////////////////
  // compare and timeout
  ////////////////////

  always @(negedge clk) begin
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("a result arrived with no operation outstanding");
        $display("*** TEST FAILED ***");
        $fatal(1, "unexpected result");
      end else begin
        exp_head = exp_q.pop_front();
        check_value("rsp_o.rdata", rsp.rdata, exp_head.rdata);
        check_value("rsp_o.err", {31'b0, rsp.err}, {31'b0, exp_head.err});
        check_value("rsp_o.we", {31'b0, rsp.we}, {31'b0, exp_head.we});
        check_value("rsp_o.addr", rsp.addr, exp_head.addr);
        n_done++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("results stopped arriving, %0d of %0d operations done", n_done, n_issued);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

endmodule

// File: lsu_core.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_req_stage.sv
hw/lsu_rsp_stage.sv
hw/lsu_core.sv
tests/lsu_mem_model.sv
tests/tb_lsu_core.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       := tb_lsu_core
FILELIST  := lsu_core.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
SRCS      := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
